// ==== rtl/estimatorPkg.sv ====
`default_nettype none

package estimatorPkg;

    // Sizes
    localparam int NumCtrl        = 2;
    localparam int BatchLen       = 8;
    localparam int BatchAddrWidth = 3;
    localparam int RegionCount    = 4;
    localparam int RegionWidth    = 2;
    localparam int BufAddrWidth   = RegionWidth + BatchAddrWidth;
    localparam int PeriodWidth    = 3;

    // Fixed point: 1 sign, 3 integer, 12 fraction bits
    localparam int FracBits   = 12;
    localparam int StateWidth = 16;
    localparam int OutWidth   = 14;

    localparam logic signed [OutWidth-1:0] OutMax = {1'b0, {(OutWidth-1){1'b1}}};
    localparam logic signed [OutWidth-1:0] OutMin = {1'b1, {(OutWidth-1){1'b0}}};

    localparam logic [BatchAddrWidth-1:0] LastIndex = 3'(BatchLen - 1);

    // Pipeline alignment: read port plus LUT register, then state and weight registers
    localparam int StartDelay = 2;
    localparam int ResDelay   = StartDelay + 2;
    localparam logic [PeriodWidth-1:0]    ComputePeriod = 3'd3;
    localparam logic [PeriodWidth-1:0]    ValidPeriod   = 3'd4;
    localparam logic [BatchAddrWidth-1:0] ValidIndex    = 3'd5;

    // Recursion factors, magnitude about 0.9
    localparam logic signed [StateWidth-1:0] LfR = 16'sd3500;
    localparam logic signed [StateWidth-1:0] LfI = 16'sd1200;
    localparam logic signed [StateWidth-1:0] LbR = 16'sd3400;
    localparam logic signed [StateWidth-1:0] LbI = -16'sd1300;

    // Input tables, entry 0 first
    localparam logic signed [0:NumCtrl-1][StateWidth-1:0] FfR = {16'sd500, 16'sd700};
    localparam logic signed [0:NumCtrl-1][StateWidth-1:0] FfI = {-16'sd150, 16'sd200};
    localparam logic signed [0:NumCtrl-1][StateWidth-1:0] FbR = {16'sd450, 16'sd650};
    localparam logic signed [0:NumCtrl-1][StateWidth-1:0] FbI = {16'sd120, -16'sd180};

    // Output weights
    localparam logic signed [StateWidth-1:0] WfR = 16'sd3000;
    localparam logic signed [StateWidth-1:0] WfI = -16'sd1000;
    localparam logic signed [StateWidth-1:0] WbR = 16'sd2800;
    localparam logic signed [StateWidth-1:0] WbI = 16'sd900;

    // Truncating fixed-point product, result wraps to StateWidth
    function automatic logic signed [StateWidth-1:0] mulFix(
        input logic signed [StateWidth-1:0] a,
        input logic signed [StateWidth-1:0] b
    );
        logic signed [2*StateWidth-1:0] prod;
        prod = a * b;
        return prod[FracBits +: StateWidth];
    endfunction

endpackage

`default_nettype wire

// ==== rtl/batchSequencer.sv ====
`default_nettype none

module batchSequencer (
    input  wire                                       clkDS,
    input  wire                                       rst,
    output logic [estimatorPkg::BufAddrWidth-1:0]     writeAddr,
    output logic [estimatorPkg::BufAddrWidth-1:0]     lookAddr,
    output logic [estimatorPkg::BufAddrWidth-1:0]     fwdAddr,
    output logic [estimatorPkg::BufAddrWidth-1:0]     bwdAddr,
    output logic                                      loadStart,
    output logic                                      computeEnable,
    output logic [estimatorPkg::BatchAddrWidth-1:0]   resWriteAddrF,
    output logic [estimatorPkg::BatchAddrWidth-1:0]   resWriteAddrB,
    output logic [estimatorPkg::BatchAddrWidth-1:0]   resReadAddr,
    output logic                                      resBank,
    output logic                                      estimateValid
);
    import estimatorPkg::*;

    logic [BatchAddrWidth-1:0] idx;
    logic [BatchAddrWidth-1:0] idxRev;
    logic [RegionWidth-1:0]    writeReg;
    logic [RegionWidth-1:0]    lookReg;
    logic [RegionWidth-1:0]    idleReg;
    logic [RegionWidth-1:0]    compReg;
    logic [PeriodWidth-1:0]    periodCount;
    logic [StartDelay-1:0]     startPipe;
    logic [BatchAddrWidth-1:0] idxPipe [ResDelay];
    logic [BatchAddrWidth-1:0] idxRevPipe [ResDelay];
    logic [ResDelay-1:0]       bankPipe;
    logic                      periodEnd;

    assign periodEnd = (idx == LastIndex);

    // Batch counters and region rotation
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            idx         <= '0;
            idxRev      <= LastIndex;
            writeReg    <= 2'd0;
            lookReg     <= 2'd3;
            idleReg     <= 2'd2;
            compReg     <= 2'd1;
            periodCount <= '0;
        end else begin
            idx    <= idx + 1'b1;
            idxRev <= idxRev - 1'b1;
            if (periodEnd) begin
                writeReg <= writeReg + 1'b1;
                lookReg  <= writeReg;
                idleReg  <= lookReg;
                compReg  <= idleReg;
                if (periodCount != ValidPeriod) begin
                    periodCount <= periodCount + 1'b1;
                end
            end
        end
    end

    // Strobes and result addresses follow the data through the pipeline
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            startPipe     <= '0;
            bankPipe      <= '0;
            computeEnable <= 1'b0;
            estimateValid <= 1'b0;
            for (int i = 0; i < ResDelay; i++) begin
                idxPipe[i]    <= '0;
                idxRevPipe[i] <= '0;
            end
        end else begin
            startPipe     <= {startPipe[StartDelay-2:0], idx == '0};
            bankPipe      <= {bankPipe[ResDelay-2:0], compReg[0]};
            idxPipe[0]    <= idx;
            idxRevPipe[0] <= idxRev;
            for (int i = 1; i < ResDelay; i++) begin
                idxPipe[i]    <= idxPipe[i-1];
                idxRevPipe[i] <= idxRevPipe[i-1];
            end
            // Batch 0 reaches the forward recursion input
            if (startPipe[StartDelay-2] && periodCount == ComputePeriod) begin
                computeEnable <= 1'b1;
            end
            if (periodCount == ValidPeriod && idx == ValidIndex) begin
                estimateValid <= 1'b1;
            end
        end
    end

    assign writeAddr = {writeReg, idx};
    assign lookAddr  = {lookReg, idxRev};
    assign fwdAddr   = {compReg, idx};
    assign bwdAddr   = {compReg, idxRev};

    assign loadStart     = startPipe[StartDelay-1];
    assign resWriteAddrF = idxPipe[ResDelay-1];
    assign resWriteAddrB = idxRevPipe[ResDelay-1];
    assign resReadAddr   = idxPipe[ResDelay-1];
    assign resBank       = bankPipe[ResDelay-1];

    regionsDistinct: assert property (@(posedge clkDS) disable iff (!rst)
        writeReg != lookReg && writeReg != compReg && lookReg != compReg
        && idleReg != compReg && idleReg != writeReg)
        else $error("sample buffer regions overlap");

    // Backward walk must start its batch when the load lands
    loadOnBoundary: assert property (@(posedge clkDS) disable iff (!rst)
        loadStart |-> $past(idxRev, StartDelay) == LastIndex)
        else $error("recursion load away from a period boundary");

    validAfterCompute: assert property (@(posedge clkDS) disable iff (!rst)
        estimateValid |-> computeEnable && periodCount == ValidPeriod)
        else $error("estimateValid high before the compute pipeline is full");

endmodule

`default_nettype wire

// ==== rtl/sampleBuffer.sv ====
`default_nettype none

module sampleBuffer (
    input  wire                                    clkDS,
    input  wire  [estimatorPkg::NumCtrl-1:0]       ctrlIn,
    input  wire  [estimatorPkg::BufAddrWidth-1:0]  writeAddr,
    input  wire  [estimatorPkg::BufAddrWidth-1:0]  lookAddr,
    input  wire  [estimatorPkg::BufAddrWidth-1:0]  fwdAddr,
    input  wire  [estimatorPkg::BufAddrWidth-1:0]  bwdAddr,
    output logic [estimatorPkg::NumCtrl-1:0]       lookCtrl,
    output logic [estimatorPkg::NumCtrl-1:0]       fwdCtrl,
    output logic [estimatorPkg::NumCtrl-1:0]       bwdCtrl
);
    import estimatorPkg::*;

    // Four regions of one batch each
    logic [NumCtrl-1:0] mem [RegionCount*BatchLen];

    always_ff @(posedge clkDS) begin
        mem[writeAddr] <= ctrlIn;
    end

    // Read regions never match the write region
    always_ff @(posedge clkDS) begin
        lookCtrl <= mem[lookAddr];
        fwdCtrl  <= mem[fwdAddr];
        bwdCtrl  <= mem[bwdAddr];
    end

endmodule

`default_nettype wire

// ==== rtl/controlLut.sv ====
`default_nettype none

module controlLut #(
    parameter bit useForward = 1'b1
) (
    input  wire                                        clkDS,
    input  wire         [estimatorPkg::NumCtrl-1:0]    ctrl,
    output logic signed [estimatorPkg::StateWidth-1:0] termR,
    output logic signed [estimatorPkg::StateWidth-1:0] termI
);
    import estimatorPkg::*;

    logic signed [StateWidth-1:0] sumR;
    logic signed [StateWidth-1:0] sumI;

    // Each bit adds its entry when set and subtracts it when clear
    always_comb begin
        sumR = '0;
        sumI = '0;
        for (int i = 0; i < NumCtrl; i++) begin
            if (ctrl[i]) begin
                sumR = sumR + (useForward ? $signed(FfR[i]) : $signed(FbR[i]));
                sumI = sumI + (useForward ? $signed(FfI[i]) : $signed(FbI[i]));
            end else begin
                sumR = sumR - (useForward ? $signed(FfR[i]) : $signed(FbR[i]));
                sumI = sumI - (useForward ? $signed(FfI[i]) : $signed(FbI[i]));
            end
        end
    end

    always_ff @(posedge clkDS) begin
        termR <= sumR;
        termI <= sumI;
    end

endmodule

`default_nettype wire

// ==== rtl/complexRecursion.sv ====
`default_nettype none

module complexRecursion #(
    parameter bit useForward = 1'b1
) (
    input  wire                                        clkDS,
    input  wire                                        rst,
    input  wire  signed [estimatorPkg::StateWidth-1:0] inR,
    input  wire  signed [estimatorPkg::StateWidth-1:0] inI,
    input  wire                                        loadStart,
    input  wire  signed [estimatorPkg::StateWidth-1:0] startR,
    input  wire  signed [estimatorPkg::StateWidth-1:0] startI,
    output logic signed [estimatorPkg::StateWidth-1:0] stateR,
    output logic signed [estimatorPkg::StateWidth-1:0] stateI
);
    import estimatorPkg::*;

    logic signed [StateWidth-1:0] factorR;
    logic signed [StateWidth-1:0] factorI;
    logic signed [StateWidth-1:0] nextR;
    logic signed [StateWidth-1:0] nextI;

    assign factorR = useForward ? LfR : LbR;
    assign factorI = useForward ? LfI : LbI;

    // Load replaces the feedback term, input is still added
    always_comb begin
        if (loadStart) begin
            nextR = startR + inR;
            nextI = startI + inI;
        end else begin
            nextR = mulFix(factorR, stateR) - mulFix(factorI, stateI) + inR;
            nextI = mulFix(factorR, stateI) + mulFix(factorI, stateR) + inI;
        end
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            stateR <= '0;
            stateI <= '0;
        end else begin
            stateR <= nextR;
            stateI <= nextI;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/resultCombiner.sv ====
`default_nettype none

module resultCombiner (
    input  wire                                         clkDS,
    input  wire                                         rst,
    input  wire  signed [estimatorPkg::StateWidth-1:0]  fwdR,
    input  wire  signed [estimatorPkg::StateWidth-1:0]  fwdI,
    input  wire  signed [estimatorPkg::StateWidth-1:0]  bwdR,
    input  wire  signed [estimatorPkg::StateWidth-1:0]  bwdI,
    input  wire         [estimatorPkg::BatchAddrWidth-1:0] resWriteAddrF,
    input  wire         [estimatorPkg::BatchAddrWidth-1:0] resWriteAddrB,
    input  wire         [estimatorPkg::BatchAddrWidth-1:0] resReadAddr,
    input  wire                                         resBank,
    output logic        [estimatorPkg::OutWidth-1:0]    estimate
);
    import estimatorPkg::*;

    logic signed [StateWidth-1:0] weightF;
    logic signed [StateWidth-1:0] weightB;
    logic signed [StateWidth-1:0] storeF [2*BatchLen];
    logic signed [StateWidth-1:0] storeB [2*BatchLen];
    logic signed [StateWidth-1:0] readF;
    logic signed [StateWidth-1:0] readB;
    logic signed [OutWidth-1:0]   partF;
    logic signed [OutWidth-1:0]   partB;
    logic signed [StateWidth:0]   sumWide;
    logic signed [OutWidth-1:0]   sum;

    function automatic logic signed [OutWidth-1:0] clip(input logic signed [StateWidth:0] v);
        if (v > OutMax) begin
            return OutMax;
        end else if (v < OutMin) begin
            return OutMin;
        end
        return v[OutWidth-1:0];
    endfunction

    // Real part of the weighted state
    always_ff @(posedge clkDS) begin
        weightF <= mulFix(WfR, fwdR) - mulFix(WfI, fwdI);
        weightB <= mulFix(WbR, bwdR) - mulFix(WbI, bwdI);
    end

    // Backward results land at their descending index, so an ascending
    // read of the other bank pairs them with the forward results
    always_ff @(posedge clkDS) begin
        storeF[{resBank, resWriteAddrF}] <= weightF;
        storeB[{resBank, resWriteAddrB}] <= weightB;
        readF <= storeF[{~resBank, resReadAddr}];
        readB <= storeB[{~resBank, resReadAddr}];
    end

    // Scale by two into the output format
    assign partF   = clip({readF, 1'b0});
    assign partB   = clip({readB, 1'b0});
    assign sumWide = partF + partB;
    assign sum     = clip(sumWide);

    // Offset binary out
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            estimate <= '0;
        end else begin
            estimate <= {~sum[OutWidth-1], sum[OutWidth-2:0]};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/batchEstimatorTop.sv ====
`default_nettype none

module batchEstimatorTop (
    input  wire                                clkDS,
    input  wire                                rst,
    input  wire  [estimatorPkg::NumCtrl-1:0]   ctrlIn,
    output logic [estimatorPkg::OutWidth-1:0]  estimate,
    output logic                               estimateValid
);
    import estimatorPkg::*;

    logic [BufAddrWidth-1:0]   writeAddr;
    logic [BufAddrWidth-1:0]   lookAddr;
    logic [BufAddrWidth-1:0]   fwdAddr;
    logic [BufAddrWidth-1:0]   bwdAddr;
    logic                      loadStart;
    logic                      computeEnable;
    logic [BatchAddrWidth-1:0] resWriteAddrF;
    logic [BatchAddrWidth-1:0] resWriteAddrB;
    logic [BatchAddrWidth-1:0] resReadAddr;
    logic                      resBank;

    logic [NumCtrl-1:0] lookCtrl;
    logic [NumCtrl-1:0] fwdCtrl;
    logic [NumCtrl-1:0] bwdCtrl;

    logic signed [StateWidth-1:0] lookTermR;
    logic signed [StateWidth-1:0] lookTermI;
    logic signed [StateWidth-1:0] fwdTermR;
    logic signed [StateWidth-1:0] fwdTermI;
    logic signed [StateWidth-1:0] bwdTermR;
    logic signed [StateWidth-1:0] bwdTermI;
    logic signed [StateWidth-1:0] fwdInR;
    logic signed [StateWidth-1:0] fwdInI;

    logic signed [StateWidth-1:0] lookStateR;
    logic signed [StateWidth-1:0] lookStateI;
    logic signed [StateWidth-1:0] fwdStateR;
    logic signed [StateWidth-1:0] fwdStateI;
    logic signed [StateWidth-1:0] bwdStateR;
    logic signed [StateWidth-1:0] bwdStateI;

    batchSequencer sequencer (
        .clkDS         (clkDS),
        .rst           (rst),
        .writeAddr     (writeAddr),
        .lookAddr      (lookAddr),
        .fwdAddr       (fwdAddr),
        .bwdAddr       (bwdAddr),
        .loadStart     (loadStart),
        .computeEnable (computeEnable),
        .resWriteAddrF (resWriteAddrF),
        .resWriteAddrB (resWriteAddrB),
        .resReadAddr   (resReadAddr),
        .resBank       (resBank),
        .estimateValid (estimateValid)
    );

    sampleBuffer samples (
        .clkDS     (clkDS),
        .ctrlIn    (ctrlIn),
        .writeAddr (writeAddr),
        .lookAddr  (lookAddr),
        .fwdAddr   (fwdAddr),
        .bwdAddr   (bwdAddr),
        .lookCtrl  (lookCtrl),
        .fwdCtrl   (fwdCtrl),
        .bwdCtrl   (bwdCtrl)
    );

    controlLut #(.useForward(1'b0)) lookLut (
        .clkDS (clkDS),
        .ctrl  (lookCtrl),
        .termR (lookTermR),
        .termI (lookTermI)
    );

    controlLut #(.useForward(1'b1)) fwdLut (
        .clkDS (clkDS),
        .ctrl  (fwdCtrl),
        .termR (fwdTermR),
        .termI (fwdTermI)
    );

    controlLut #(.useForward(1'b0)) bwdLut (
        .clkDS (clkDS),
        .ctrl  (bwdCtrl),
        .termR (bwdTermR),
        .termI (bwdTermI)
    );

    // No forward input until batch 0 arrives
    assign fwdInR = computeEnable ? fwdTermR : '0;
    assign fwdInI = computeEnable ? fwdTermI : '0;

    // Lookahead restarts from zero each period
    complexRecursion #(.useForward(1'b0)) lookRec (
        .clkDS     (clkDS),
        .rst       (rst),
        .inR       (lookTermR),
        .inI       (lookTermI),
        .loadStart (loadStart),
        .startR    ('0),
        .startI    ('0),
        .stateR    (lookStateR),
        .stateI    (lookStateI)
    );

    complexRecursion #(.useForward(1'b0)) bwdRec (
        .clkDS     (clkDS),
        .rst       (rst),
        .inR       (bwdTermR),
        .inI       (bwdTermI),
        .loadStart (loadStart),
        .startR    (lookStateR),
        .startI    (lookStateI),
        .stateR    (bwdStateR),
        .stateI    (bwdStateI)
    );

    complexRecursion #(.useForward(1'b1)) fwdRec (
        .clkDS     (clkDS),
        .rst       (rst),
        .inR       (fwdInR),
        .inI       (fwdInI),
        .loadStart (1'b0),
        .startR    ('0),
        .startI    ('0),
        .stateR    (fwdStateR),
        .stateI    (fwdStateI)
    );

    resultCombiner combiner (
        .clkDS         (clkDS),
        .rst           (rst),
        .fwdR          (fwdStateR),
        .fwdI          (fwdStateI),
        .bwdR          (bwdStateR),
        .bwdI          (bwdStateI),
        .resWriteAddrF (resWriteAddrF),
        .resWriteAddrB (resWriteAddrB),
        .resReadAddr   (resReadAddr),
        .resBank       (resBank),
        .estimate      (estimate)
    );

endmodule

`default_nettype wire

// ==== sim/tbBatchEstimator.sv ====
`default_nettype none

module tbBatchEstimator;
    timeunit 1ns;
    timeprecision 1ps;

    import estimatorPkg::*;

    typedef logic [NumCtrl-1:0]  ctrlQueue[$];
    typedef logic [OutWidth-1:0] estQueue[$];

    localparam int ClkPeriod     = 20;
    localparam int FirstBatches  = 64;
    localparam int SecondBatches = 12;
    // Stimulus plus six batches of pipeline drain per run
    localparam int WatchdogCycles = (FirstBatches + SecondBatches) * BatchLen
                                    + 2 * 6 * BatchLen;

    logic                clkDS;
    logic                rst;
    logic [NumCtrl-1:0]  ctrlIn;
    logic [OutWidth-1:0] estimate;
    logic                estimateValid;

    logic [15:0] lfsrState;
    ctrlQueue    stim;
    estQueue     expQ;
    int          checkCount;
    int          mismatchCount;
    int          otherErrors;
    int          estimatesSeen;
    int          lowCycles;
    bit          wasValid;

    batchEstimatorTop dut (
        .clkDS         (clkDS),
        .rst           (rst),
        .ctrlIn        (ctrlIn),
        .estimate      (estimate),
        .estimateValid (estimateValid)
    );

    always #(ClkPeriod / 2) clkDS = ~clkDS;

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        checkCount++;
        if (got !== want) begin
            mismatchCount++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
        end
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic void appendRandom(input int batches);
        logic [NumCtrl-1:0] value;
        for (int s = 0; s < batches * BatchLen; s++) begin
            for (int b = 0; b < NumCtrl; b++) begin
                lfsrState = lfsrStep(lfsrState);
                value[b] = lfsrState[0];
            end
            stim.push_back(value);
        end
    endfunction

    function automatic void appendConstant(input logic [NumCtrl-1:0] value, input int batches);
        for (int s = 0; s < batches * BatchLen; s++) begin
            stim.push_back(value);
        end
    endfunction

    // Runs of ones and zeros near the forward resonance
    function automatic void appendAlternating(input int batches, input int runLength);
        for (int s = 0; s < batches * BatchLen; s++) begin
            stim.push_back(((s / runLength) % 2 == 0) ? '1 : '0);
        end
    endfunction

    function automatic int wrapState(input int v);
        logic signed [StateWidth-1:0] t;
        t = v[StateWidth-1:0];
        return int'(t);
    endfunction

    function automatic int truncProduct(input int a, input int b);
        int p;
        p = a * b;
        return wrapState(p >>> FracBits);
    endfunction

    function automatic void inputTerm(input logic [NumCtrl-1:0] ctrl, input bit forward,
                                      output int tr, output int ti);
        int er;
        int ei;
        tr = 0;
        ti = 0;
        for (int i = 0; i < NumCtrl; i++) begin
            if (forward) begin
                er = int'($signed(FfR[i]));
                ei = int'($signed(FfI[i]));
            end else begin
                er = int'($signed(FbR[i]));
                ei = int'($signed(FbI[i]));
            end
            if (ctrl[i]) begin
                tr += er;
                ti += ei;
            end else begin
                tr -= er;
                ti -= ei;
            end
        end
        tr = wrapState(tr);
        ti = wrapState(ti);
    endfunction

    function automatic void stepState(input int fr, input int fi, inout int sr, inout int si,
                                      input int tr, input int ti);
        int nr;
        int ni;
        nr = truncProduct(fr, sr) - truncProduct(fi, si) + tr;
        ni = truncProduct(fr, si) + truncProduct(fi, sr) + ti;
        sr = wrapState(nr);
        si = wrapState(ni);
    endfunction

    function automatic int weightReal(input int wr, input int wi, input int sr, input int si);
        return wrapState(truncProduct(wr, sr) - truncProduct(wi, si));
    endfunction

    function automatic int clipOut(input int v);
        int hi;
        hi = (1 << (OutWidth - 1)) - 1;
        if (v > hi) begin
            return hi;
        end else if (v < -hi - 1) begin
            return -hi - 1;
        end
        return v;
    endfunction

    function automatic logic [OutWidth-1:0] outputCode(input int wf, input int wb);
        int code;
        code = clipOut(clipOut(2 * wf) + clipOut(2 * wb)) + (1 << (OutWidth - 1));
        return code[OutWidth-1:0];
    endfunction

    // Expected estimates for every batch that has a following batch
    function automatic estQueue referenceModel(input ctrlQueue stimIn);
        estQueue result;
        int      fwdWeight[$];
        int      bwdWeight[BatchLen];
        int      batches;
        int      base;
        int      fR;
        int      fI;
        int      lR;
        int      lI;
        int      bR;
        int      bI;
        int      tR;
        int      tI;
        batches = stimIn.size() / BatchLen;
        fR = 0;
        fI = 0;
        for (int s = 0; s < stimIn.size(); s++) begin
            inputTerm(stimIn[s], 1'b1, tR, tI);
            stepState(LfR, LfI, fR, fI, tR, tI);
            fwdWeight.push_back(weightReal(WfR, WfI, fR, fI));
        end
        for (int b = 0; b + 1 < batches; b++) begin
            // Lookahead over the next batch from zero
            base = (b + 1) * BatchLen;
            inputTerm(stimIn[base + BatchLen - 1], 1'b0, lR, lI);
            for (int j = BatchLen - 2; j >= 0; j--) begin
                inputTerm(stimIn[base + j], 1'b0, tR, tI);
                stepState(LbR, LbI, lR, lI, tR, tI);
            end
            base = b * BatchLen;
            inputTerm(stimIn[base + BatchLen - 1], 1'b0, tR, tI);
            bR = wrapState(lR + tR);
            bI = wrapState(lI + tI);
            bwdWeight[BatchLen-1] = weightReal(WbR, WbI, bR, bI);
            for (int j = BatchLen - 2; j >= 0; j--) begin
                inputTerm(stimIn[base + j], 1'b0, tR, tI);
                stepState(LbR, LbI, bR, bI, tR, tI);
                bwdWeight[j] = weightReal(WbR, WbI, bR, bI);
            end
            for (int k = 0; k < BatchLen; k++) begin
                result.push_back(outputCode(fwdWeight[base + k], bwdWeight[k]));
            end
        end
        return result;
    endfunction

    // Enters with rst low, releases it and streams the stimulus
    task automatic applyRun(input bit needsClipping);
        estQueue model;
        int      clipped;
        model = referenceModel(stim);
        clipped = 0;
        foreach (model[i]) begin
            if (model[i] == '1 || model[i] == '0) begin
                clipped++;
            end
        end
        $display("run of %0d samples, %0d estimates expected, %0d of them clipped",
                 stim.size(), model.size(), clipped);
        if (needsClipping && clipped == 0) begin
            otherErrors++;
            $display("stimulus reaches no saturated estimate");
        end
        expQ = model;
        repeat (2) @(posedge clkDS);
        rst <= 1'b1;
        for (int k = 0; k < stim.size(); k++) begin
            ctrlIn <= stim[k];
            @(posedge clkDS);
        end
        while (expQ.size() != 0) begin
            @(posedge clkDS);
        end
    endtask

    // Compares one estimate per valid cycle
    always @(negedge clkDS) begin
        if (!rst) begin
            wasValid = 1'b0;
            lowCycles = 0;
            estimatesSeen = 0;
        end else if (!estimateValid) begin
            if (wasValid) begin
                otherErrors++;
                $display("estimateValid fell at %0t while reset was released", $time);
            end
            wasValid = 1'b0;
            lowCycles++;
        end else begin
            if (!wasValid && lowCycles < 3 * BatchLen) begin
                otherErrors++;
                $display("estimateValid rose after only %0d cycles out of reset", lowCycles);
            end
            wasValid = 1'b1;
            if (expQ.size() != 0) begin
                checkValue($sformatf("estimate[%0d]", estimatesSeen), estimate,
                           expQ.pop_front());
                estimatesSeen++;
            end
        end
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("run timed out after %0d cycles with %0d estimates outstanding",
                 WatchdogCycles, expQ.size());
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checkCount, mismatchCount, otherErrors + 1);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        clkDS = 1'b0;
        rst = 1'b0;
        ctrlIn = '0;
        lfsrState = 16'd91;
        checkCount = 0;
        mismatchCount = 0;
        otherErrors = 0;
        estimatesSeen = 0;
        lowCycles = 0;
        wasValid = 1'b0;

        // Random batches, then constant and alternating runs
        appendRandom(40);
        appendConstant('1, 6);
        appendConstant('0, 6);
        appendAlternating(FirstBatches - 52, 9);
        applyRun(1'b1);

        // Reset while the estimator is still streaming
        rst <= 1'b0;
        @(negedge clkDS);
        checkValue("estimateValid", estimateValid, 1'b0);
        stim.delete();
        appendRandom(SecondBatches);
        applyRun(1'b0);

        $display("checks %0d, mismatches %0d, other errors %0d",
                 checkCount, mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/estimatorPkg.sv
rtl/batchSequencer.sv
rtl/sampleBuffer.sv
rtl/controlLut.sv
rtl/complexRecursion.sv
rtl/resultCombiner.sv
rtl/batchEstimatorTop.sv
sim/tbBatchEstimator.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the batch estimator testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tbBatchEstimator -Mdir "$BUILD_DIR" -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/VtbBatchEstimator" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG_FILE"; then
    exit 1
fi
exit 0
